// ==== pongTop.f ====
displayPkg.sv
gamePkg.sv
vgaTiming.sv
gameControl.sv
digitGlyph.sv
pixelRenderer.sv
scoreDisplay.sv
pongTop.sv
clockGen.sv
pongTop_checker.sv
pongTopTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the Pong testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pongTopTb \
	-f pongTop.f -o pongSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/pongSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q "Testbench passed" sim.log; then
	exit 0
fi
exit 1

// ==== pongTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pongTopTb import displayPkg::*, gamePkg::*;
();

	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int ROUND_CYCLES = 56;		// One strobe per 8 clocks, 7 strobes a round
	localparam int RANDOM_ROUNDS = 3000;
	localparam int WATCHDOG_CYCLES = 1000 + 4 * FRAME + 6_000_000
		+ RANDOM_ROUNDS * ROUND_CYCLES + 3 * FRAME + 2 * FRAME + 100_000;

	logic DIV_CLK;
	logic reset;
	logic gameStep = 1'b0;
	logic stepEnable = 1'b0;
	logic [2:0] stepPhase = '0;
	logic startButton;
	logic [7:0] pot1;
	logic [7:0] pot2;
	logic [7:0] colorSwitches;
	logic hSync;
	logic vSync;
	logic [2:0] vgaRed;
	logic [2:0] vgaGreen;
	logic [1:0] vgaBlue;
	logic [3:0] anodes;
	segments_t cathodes;

	int errors = 0;
	int testsFailed = 0;

	// Game model
	gameState_e mState;
	logic [X_BITS-1:0] mX;
	logic [Y_BITS-1:0] mY;
	logic [X_BITS-1:0] mRightX;
	logic [Y_BITS-1:0] mCenterY;
	logic [Y_BITS-1:0] mLeftY;
	logic [Y_BITS-1:0] mRightY;
	logic [SPEED_BITS-1:0] mSpX;
	logic [SPEED_BITS-1:0] mSpY;
	logic mDirX;
	logic mDirY;
	logic [7:0] mColor;
	int mHits;
	int mWait;
	int mP1;
	int mP2;

	// Screen position tracker
	int scanX = 0;
	int scanY = 0;
	bit posValid = 0;
	logic prevV = 1'b1;
	logic prevH = 1'b1;
	bit checkBlank = 0;
	int borderRow = -1;
	int borderChecks = 0;

	clockGen clockSource (.DIV_CLK, .reset);

	pongTop pongTop_inst
	(
		.DIV_CLK, .reset, .gameStep, .startButton, .pot1, .pot2, .colorSwitches,
		.hSync, .vSync, .vgaRed, .vgaGreen, .vgaBlue, .anodes, .cathodes
	);

	// Strobe every eighth clock
	always @(posedge DIV_CLK)
	begin
		stepPhase <= stepPhase + 1'b1;
		gameStep <= stepEnable && (stepPhase == 3'd7);
	end

	task automatic reportValue(input string name, input int expected, input int got);
		$display("error at %0t: %s expected %0d got %0d", $time, name, expected, got);
		errors++;
	endtask

	task automatic reportFailure(input string msg);
		$display("at %0t: %s", $time, msg);
		errors++;
	endtask

	function automatic logic [Y_BITS-1:0] paddleFromPot(input logic [7:0] pot);
		int doubled;
		doubled = 2 * pot;
		if (doubled < POT_DEADZONE)
			return '0;
		if (doubled - POT_DEADZONE > PADDLE_MAX_Y)
			return Y_BITS'(PADDLE_MAX_Y);	// Bottom clamp
		return Y_BITS'(doubled - POT_DEADZONE);
	endfunction

	function automatic int segToDigit(input segments_t seg);
		case (seg)
			7'b0000001: return 0;
			7'b1001111: return 1;
			7'b0010010: return 2;
			7'b0000110: return 3;
			7'b1001100: return 4;
			7'b0100100: return 5;
			default: return 15;			// Not a score
		endcase
	endfunction

	task automatic serveAfterScore(input logic dirX);
		mX = X_BITS'(BALL_START_X);
		mY = Y_BITS'(BALL_START_Y);
		mDirX = dirX;
		mDirY = 1'b0;
		mSpX = SPEED_BITS'(SERVE_SPEED);
		mSpY = SPEED_BITS'(SERVE_SPEED);
		mHits = 0;
		mWait = 0;
	endtask

	////////////////////
	// One game step of the model
	task automatic stepModel();
		logic leftHit;
		logic rightHit;
		logic speedUp;
		logic [SPEED_BITS-1:0] oldSpeed;
		case (mState)
			sIdle:
				if (startButton)
				begin
					mP1 = 0;
					mP2 = 0;
					serveAfterScore(1'b1);
					mSpX = SPEED_BITS'(START_SPEED);
					mSpY = SPEED_BITS'(START_SPEED);
					mState = sServeWait;
				end
			sServeWait:
				if (mWait == SERVE_WAIT_STEPS - 1)
				begin
					mWait = 0;
					mState = sPaddles;
				end
				else
					mWait++;
			sPaddles:
			begin
				mLeftY = paddleFromPot(pot1);
				mRightY = paddleFromPot(pot2);
				mColor = colorSwitches;
				if (mWait == PADDLE_REPEATS - 1)
				begin
					mWait = 0;
					mState = sBallMove;
				end
				else
					mWait++;
			end
			sBallMove:
			begin
				mX = mDirX ? mX + mSpX : mX - mSpX;
				mY = mDirY ? mY + mSpY : mY - mSpY;
				mState = sBallEdge;
			end
			sBallEdge:
			begin
				mRightX = mX + BALL_SIZE;
				mCenterY = mY + BALL_SIZE / 2;
				mState = sCollide;
			end
			sCollide:
			begin
				leftHit = (mX >= LEFT_PADDLE_X) && (mX < LEFT_PADDLE_X + PADDLE_W)
					&& (mCenterY >= mLeftY) && (mCenterY < mLeftY + PADDLE_H);
				rightHit = (mRightX >= RIGHT_PADDLE_X) && (mRightX < RIGHT_PADDLE_X + PADDLE_W)
					&& (mCenterY >= mRightY) && (mCenterY < mRightY + PADDLE_H);
				if (mY < mSpY)
					mDirY = 1'b1;
				else if (mY >= WALL_BOTTOM_Y)
					mDirY = 1'b0;
				if (leftHit)
					mDirX = 1'b1;
				if (rightHit)
					mDirX = 1'b0;
				speedUp = (leftHit || rightHit) && (mHits == HITS_PER_SPEEDUP - 1);
				if (leftHit || rightHit)
					mHits = speedUp ? 0 : mHits + 1;
				oldSpeed = mSpX;
				if (speedUp)
				begin
					mSpX++;
					mSpY++;
				end
				if (mX < oldSpeed)
					mState = sP2Score;
				else if (mX >= GOAL_RIGHT_X)
					mState = sP1Score;
				else
					mState = sPaddles;
			end
			sP1Score:
			begin
				mState = (mP1 == WIN_SCORE - 1) ? sP1Win : sServeWait;
				mP1++;
				serveAfterScore(1'b0);
			end
			sP2Score:
			begin
				mState = (mP2 == WIN_SCORE - 1) ? sP2Win : sServeWait;
				mP2++;
				serveAfterScore(1'b1);
			end
			sP1Win, sP2Win:
			begin
				mWait = 0;
				mState = sEndWait;
			end
			default:
				if (mWait == END_WAIT_STEPS - 1)
				begin
					mWait = 0;
					mState = sIdle;
				end
				else
					mWait++;
		endcase
	endtask

	always @(posedge DIV_CLK)
	begin
		if (reset)
		begin
			mState = sIdle;
			mP1 = 0;
			mP2 = 0;
			mWait = 0;
			mColor = '0;
		end
		else if (gameStep)
			stepModel();
	end

	////////////////////
	// Pixel position from the sync outputs, with blanking and border checks
	always @(negedge DIV_CLK)
	begin
		if (reset)
			posValid = 0;
		else
		begin
			if (prevV && !vSync)
			begin
				scanX = 0;					// vSync falls at the start of line 490
				scanY = V_VISIBLE + V_FRONT;
				posValid = 1;
			end
			else
			begin
				scanX++;
				if (scanX == H_TOTAL)
				begin
					scanX = 0;
					scanY = (scanY + 1) % V_TOTAL;
				end
			end
			if (posValid && prevH && !hSync && scanX != H_VISIBLE + H_FRONT)
				reportFailure("hSync fell at an unexpected pixel position");
			if (posValid && checkBlank && (scanX >= H_VISIBLE || scanY >= V_VISIBLE)
				&& {vgaRed, vgaGreen, vgaBlue} != 8'h00)
				reportValue("vgaRed/vgaGreen/vgaBlue", 0, {vgaRed, vgaGreen, vgaBlue});
			if (posValid && scanY == borderRow && (scanX == BORDER_X || scanX == BORDER_X + 1))
			begin
				borderChecks++;
				if ({vgaRed, vgaGreen, vgaBlue} != mColor)
					reportValue("vgaRed/vgaGreen/vgaBlue", mColor, {vgaRed, vgaGreen, vgaBlue});
			end
			prevV = vSync;
			prevH = hSync;
		end
	end

	// Decode a full scan of the four digits and compare
	task automatic checkDigits(input int expP1, input int expP2);
		int digits[4];
		bit seen[4];
		int expected[4];
		int d;
		expected = '{expP2, 0, expP1, 0};
		seen = '{0, 0, 0, 0};
		repeat (4 * 2 ** (SCAN_SHIFT + 1))
		begin
			@(negedge DIV_CLK);
			d = -1;
			case (anodes)
				4'b1110: d = 0;
				4'b1101: d = 1;
				4'b1011: d = 2;
				4'b0111: d = 3;
				default: d = -1;
			endcase
			if (d >= 0)
			begin
				seen[d] = 1;
				digits[d] = segToDigit(cathodes);
			end
		end
		for (int i = 0; i < 4; i++)
			if (!seen[i])
				reportFailure($sformatf("digit %0d was never scanned", i));
			else if (digits[i] != expected[i])
				reportValue($sformatf("cathodes of digit %0d", i), expected[i], digits[i]);
	endtask

	task automatic pauseAndCheck(input bit resume);
		@(posedge DIV_CLK);
		stepEnable <= 1'b0;
		repeat (16) @(negedge DIV_CLK);
		checkDigits(mP1, mP2);
		@(posedge DIV_CLK);
		stepEnable <= resume;
	endtask

	task automatic measureFall(input bit useV, output int period);
		logic prev;
		logic now;
		bit fell;
		period = 0;
		prev = useV ? vSync : hSync;
		do
		begin
			@(negedge DIV_CLK);
			now = useV ? vSync : hSync;
			fell = prev && !now;
			prev = now;
		end while (!fell);
		do
		begin
			@(negedge DIV_CLK);
			period++;
			now = useV ? vSync : hSync;
			fell = prev && !now;
			prev = now;
		end while (!fell);
	endtask

	task automatic endTest(input string name, input int startErrors);
		if (errors == startErrors)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: FAIL with %0d errors", name, errors - startErrors);
			testsFailed++;
		end
	endtask

	function automatic logic [7:0] pickPot();
		case ($urandom % 8)
			0: return 8'd0;
			1: return 8'd20;				// Just inside the dead zone
			2: return 8'd21;
			3: return 8'd235;
			4: return 8'd236;				// First clamped value
			5: return 8'd255;
			default: return 8'($urandom);
		endcase
	endfunction

	initial
	begin
		int startErrors;
		int period;
		int prevSum;
		int row;
		int checksBefore;
		void'($urandom(80));
		startButton = 1'b0;
		pot1 = '0;
		pot2 = '0;
		colorSwitches = '0;

		// Test 1 after reset
		startErrors = errors;
		wait (!reset);
		@(negedge DIV_CLK);
		if ({vgaRed, vgaGreen, vgaBlue} != 8'h00)
			reportValue("vgaRed/vgaGreen/vgaBlue", 0, {vgaRed, vgaGreen, vgaBlue});
		if (hSync !== 1'b1)
			reportValue("hSync", 1, hSync);
		if (vSync !== 1'b1)
			reportValue("vSync", 1, vSync);
		checkDigits(0, 0);
		endTest("1 after reset", startErrors);

		// Test 2 sync periods
		startErrors = errors;
		repeat (3)
		begin
			measureFall(0, period);
			if (period != H_TOTAL)
				reportValue("hSync period", H_TOTAL, period);
		end
		measureFall(1, period);
		if (period != FRAME)
			reportValue("vSync period", FRAME, period);
		endTest("2 sync period", startErrors);

		// Test 4 missed balls up to a win
		startErrors = errors;
		@(posedge DIV_CLK);
		startButton <= 1'b1;
		stepEnable <= 1'b1;
		do @(negedge DIV_CLK); while (mState == sIdle);
		@(posedge DIV_CLK);
		startButton <= 1'b0;
		prevSum = 0;
		while (mState != sIdle)
		begin
			@(negedge DIV_CLK);
			if (mP1 + mP2 != prevSum)
			begin
				prevSum = mP1 + mP2;
				pauseAndCheck(1);
			end
		end
		pauseAndCheck(0);
		if (mP1 != WIN_SCORE && mP2 != WIN_SCORE)
			reportFailure("the game returned to idle without a winner");
		endTest("4 missed balls and win", startErrors);

		// Test 5 random paddles
		startErrors = errors;
		@(posedge DIV_CLK);
		startButton <= 1'b1;			// Restart after any win
		stepEnable <= 1'b1;
		repeat (RANDOM_ROUNDS)
		begin
			@(posedge DIV_CLK);
			pot1 <= pickPot();
			pot2 <= pickPot();
			repeat (ROUND_CYCLES - 1) @(posedge DIV_CLK);
		end
		pauseAndCheck(1);
		endTest("5 random paddles", startErrors);

		// Test 6 border colour
		startErrors = errors;
		@(posedge DIV_CLK);
		colorSwitches <= 8'($urandom);
		repeat (2) @(negedge DIV_CLK);
		while (mColor != colorSwitches || mState != sPaddles)
			@(negedge DIV_CLK);		// A late strobe still leaves the game in play
		@(posedge DIV_CLK);
		stepEnable <= 1'b0;
		repeat (16) @(posedge DIV_CLK);
		row = 100;
		while (row + 2 >= mY && row <= mY + BALL_SIZE + 2)
			row += 2 * BORDER_DASH;			// Next lit dash clear of the ball
		checksBefore = borderChecks;
		borderRow <= row;
		while (borderChecks < checksBefore + 2)
			@(posedge DIV_CLK);
		borderRow <= -1;
		endTest("6 border colour", startErrors);

		// Test 3 blanking over a frame of play
		startErrors = errors;
		@(posedge DIV_CLK);
		stepEnable <= 1'b1;
		checkBlank <= 1'b1;
		wait (posValid);
		repeat (FRAME) @(posedge DIV_CLK);
		checkBlank <= 1'b0;
		endTest("3 blanking", startErrors);

		// Bound sync and scan assertions
		if (pongTop_inst.pongTopChecks.assertFails != 0)
		begin
			$display("%0d bound assertion checks failed during the run",
				pongTop_inst.pongTopChecks.assertFails);
			errors += pongTop_inst.pongTopChecks.assertFails;
		end

		$display("6 tests run, %0d failed, %0d errors", testsFailed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge DIV_CLK);
		$display("the run took longer than the summed test lengths allow");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pongTop_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pongTop_checker import displayPkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic hSync,
	input logic [3:0] anodes,
	input logic [2:0] vgaRed,
	input logic [2:0] vgaGreen,
	input logic [1:0] vgaBlue
);

	logic scanStarted;					// Anodes valid from here on
	int hLowCount;						// Low samples of the current pulse
	int assertFails = 0;				// Failed assertions so far

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			scanStarted <= 1'b0;
			hLowCount <= 0;
		end
		else
		begin
			scanStarted <= 1'b1;
			hLowCount <= hSync ? 0 : hLowCount + 1;
		end
	end

	////////////////////
	// One digit lit at a time
	assert property (@(posedge DIV_CLK) disable iff (reset) scanStarted |-> $onehot(~anodes))
		else
		begin
			assertFails++;
			$error("anodes do not have exactly one low bit");
		end

	// Sync pulse width
	assert property (@(posedge DIV_CLK) disable iff (reset) $rose(hSync) |-> hLowCount == H_SYNC)
		else
		begin
			assertFails++;
			$error("hSync pulse is not H_SYNC cycles long");
		end

	// Black during horizontal sync
	assert property (@(posedge DIV_CLK) disable iff (reset)
		!hSync |-> {vgaRed, vgaGreen, vgaBlue} == 8'h00)
		else
		begin
			assertFails++;
			$error("RGB not black while hSync is low");
		end

endmodule

bind pongTop pongTop_checker pongTopChecks (.*);

`default_nettype wire

// ==== clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	output logic DIV_CLK,
	output logic reset
);

	localparam int HALF_PERIOD = 10;	// 20 ns clock
	localparam int RESET_CYCLES = 4;

	initial
	begin
		DIV_CLK = 1'b0;
		forever #HALF_PERIOD DIV_CLK = ~DIV_CLK;
	end

	// Reset released on a rising edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge DIV_CLK);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== pongTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pongTop import displayPkg::*, gamePkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic gameStep,
	input logic startButton,
	input logic [7:0] pot1,
	input logic [7:0] pot2,
	input logic [7:0] colorSwitches,
	output logic hSync,
	output logic vSync,
	output logic [2:0] vgaRed,
	output logic [2:0] vgaGreen,
	output logic [1:0] vgaBlue,
	output logic [3:0] anodes,
	output segments_t cathodes
);

	// Scan position
	logic inDisplayArea;
	logic [X_BITS-1:0] pixelX;
	logic [Y_BITS-1:0] pixelY;

	// Game objects
	logic [X_BITS-1:0] ballX;
	logic [Y_BITS-1:0] ballY;
	logic [Y_BITS-1:0] leftPaddleY;
	logic [Y_BITS-1:0] rightPaddleY;
	logic playing;
	colorWord_u objColor;
	logic [SCORE_BITS-1:0] p1Score;
	logic [SCORE_BITS-1:0] p2Score;

	vgaTiming timing
	(
		.DIV_CLK, .reset, .hSync, .vSync, .inDisplayArea, .pixelX, .pixelY
	);

	gameControl control
	(
		.DIV_CLK, .reset, .gameStep, .startButton, .pot1, .pot2, .colorSwitches,
		.ballX, .ballY, .leftPaddleY, .rightPaddleY, .playing, .objColor,
		.p1Score, .p2Score
	);

	pixelRenderer renderer
	(
		.DIV_CLK, .reset, .pixelX, .pixelY, .inDisplayArea,
		.ballX, .ballY, .leftPaddleY, .rightPaddleY, .playing, .objColor,
		.p1Score, .p2Score, .vgaRed, .vgaGreen, .vgaBlue
	);

	scoreDisplay scoreScan
	(
		.DIV_CLK, .reset, .p1Score, .p2Score, .anodes, .cathodes
	);

endmodule

`default_nettype wire

// ==== scoreDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreDisplay import gamePkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic [SCORE_BITS-1:0] p1Score,
	input logic [SCORE_BITS-1:0] p2Score,
	output logic [3:0] anodes,			// Active low
	output segments_t cathodes
);

	logic [SCAN_SHIFT+1:0] scanCount;	// Top two bits pick the digit
	logic [1:0] digitSel;
	logic [SCORE_BITS-1:0] digitValue;

	assign digitSel = scanCount[SCAN_SHIFT+1:SCAN_SHIFT];

	// Digit 0 right player, digit 2 left player
	always_comb
	begin
		case (digitSel)
			2'd0: digitValue = p2Score;
			2'd2: digitValue = p1Score;
			default: digitValue = '0;		// Spacer digits
		endcase
	end

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			scanCount <= '0;
			anodes <= 4'b1111;			// All dark
			cathodes <= '1;
		end
		else
		begin
			scanCount <= scanCount + 1'b1;
			anodes <= ~(4'b0001 << digitSel);
			cathodes <= hexToSegments(digitValue);
		end
	end

endmodule

`default_nettype wire

// ==== pixelRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelRenderer import displayPkg::*, gamePkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic [X_BITS-1:0] pixelX,
	input logic [Y_BITS-1:0] pixelY,
	input logic inDisplayArea,
	input logic [X_BITS-1:0] ballX,
	input logic [Y_BITS-1:0] ballY,
	input logic [Y_BITS-1:0] leftPaddleY,
	input logic [Y_BITS-1:0] rightPaddleY,
	input logic playing,
	input colorWord_u objColor,
	input logic [SCORE_BITS-1:0] p1Score,
	input logic [SCORE_BITS-1:0] p2Score,
	output logic [2:0] vgaRed,
	output logic [2:0] vgaGreen,
	output logic [1:0] vgaBlue
);

	logic ballHit;
	logic paddleHit;
	logic leftDigitHit;
	logic rightDigitHit;
	logic borderHit;
	logic [Y_BITS-1:0] dashIndex;

	assign ballHit = inBox(pixelX, pixelY, ballX, ballY, BALL_SIZE, BALL_SIZE);
	assign paddleHit = inBox(pixelX, pixelY, X_BITS'(LEFT_PADDLE_X), leftPaddleY,
		PADDLE_W, PADDLE_H)
		|| inBox(pixelX, pixelY, X_BITS'(RIGHT_PADDLE_X), rightPaddleY, PADDLE_W, PADDLE_H);

	// Even dash rows lit
	assign dashIndex = pixelY / Y_BITS'(BORDER_DASH);
	assign borderHit = inBox(pixelX, pixelY, X_BITS'(BORDER_X), '0, BORDER_W, V_VISIBLE)
		&& !dashIndex[0];

	digitGlyph leftDigit
	(
		.pixelX(pixelX),
		.pixelY(pixelY),
		.originX(X_BITS'(LEFT_DIGIT_X)),
		.originY(Y_BITS'(DIGIT_Y)),
		.value(p1Score),
		.hit(leftDigitHit)
	);

	digitGlyph rightDigit
	(
		.pixelX(pixelX),
		.pixelY(pixelY),
		.originX(X_BITS'(RIGHT_DIGIT_X)),
		.originY(Y_BITS'(DIGIT_Y)),
		.value(p2Score),
		.hit(rightDigitHit)
	);

	////////////////////
	// Ball over paddles over digits over border, all in the switch colour
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			{vgaRed, vgaGreen, vgaBlue} <= '0;
		else if (inDisplayArea && playing
			&& (ballHit || paddleHit || leftDigitHit || rightDigitHit || borderHit))
		begin
			vgaRed <= objColor.rgb.red;
			vgaGreen <= objColor.rgb.green;
			vgaBlue <= objColor.rgb.blue;
		end
		else
			{vgaRed, vgaGreen, vgaBlue} <= '0;	// Blanking or background
	end

endmodule

`default_nettype wire

// ==== digitGlyph.sv ====
`timescale 1ns/1ps
`default_nettype none

module digitGlyph import displayPkg::*, gamePkg::*;
(
	input logic [X_BITS-1:0] pixelX,
	input logic [Y_BITS-1:0] pixelY,
	input logic [X_BITS-1:0] originX,	// Top left of the glyph
	input logic [Y_BITS-1:0] originY,
	input logic [SCORE_BITS-1:0] value,
	output logic hit
);

	logic [X_BITS-1:0] col;				// Cell column 0..2
	logic [Y_BITS-1:0] row;				// Cell row 0..4
	logic inGlyph;
	logic [6:0] segOn;					// Active high a..g

	assign col = (pixelX - originX) >> DIGIT_SCALE_SHIFT;
	assign row = (pixelY - originY) >> DIGIT_SCALE_SHIFT;
	assign inGlyph = (pixelX >= originX) && (pixelY >= originY) && (col < 3) && (row < 5);
	assign segOn = ~hexToSegments(value);

	////////////////////
	// Segments on the 3x5 cell grid
	always_comb
	begin
		hit = 1'b0;
		if (inGlyph)
		begin
			if (segOn[6] && row == 0)
				hit = 1'b1;						// a
			if (segOn[5] && col == 2 && row <= 2)
				hit = 1'b1;						// b
			if (segOn[4] && col == 2 && row >= 2)
				hit = 1'b1;						// c
			if (segOn[3] && row == 4)
				hit = 1'b1;						// d
			if (segOn[2] && col == 0 && row >= 2)
				hit = 1'b1;						// e
			if (segOn[1] && col == 0 && row <= 2)
				hit = 1'b1;						// f
			if (segOn[0] && row == 2)
				hit = 1'b1;						// g across the middle
		end
	end

endmodule

`default_nettype wire

// ==== gameControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameControl import displayPkg::*, gamePkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic gameStep,				// One FSM step per strobe
	input logic startButton,
	input logic [7:0] pot1,				// Left paddle
	input logic [7:0] pot2,				// Right paddle
	input logic [7:0] colorSwitches,
	output logic [X_BITS-1:0] ballX,
	output logic [Y_BITS-1:0] ballY,
	output logic [Y_BITS-1:0] leftPaddleY,
	output logic [Y_BITS-1:0] rightPaddleY,
	output logic playing,
	output colorWord_u objColor,
	output logic [SCORE_BITS-1:0] p1Score,
	output logic [SCORE_BITS-1:0] p2Score
);

	gameState_e state;
	logic ballDirX;						// 1 moves right
	logic ballDirY;						// 1 moves down
	logic [SPEED_BITS-1:0] speedX;
	logic [SPEED_BITS-1:0] speedY;
	logic [HIT_BITS-1:0] hitCount;
	logic [WAIT_BITS-1:0] waitCount;	// Serve, paddle and end waits
	logic [X_BITS-1:0] ballRightX;
	logic [Y_BITS-1:0] ballCenterY;
	logic leftHit;
	logic rightHit;
	logic speedUp;

	// Doubled pot with dead zone and bottom clamp
	function automatic logic [Y_BITS-1:0] potToPaddle(input logic [7:0] pot);
		logic [8:0] scaled;
		scaled = {pot, 1'b0};
		if (scaled < 9'(POT_DEADZONE))
			return '0;
		else if (scaled - 9'(POT_DEADZONE) > 9'(PADDLE_MAX_Y))
			return Y_BITS'(PADDLE_MAX_Y);
		else
			return Y_BITS'(scaled - 9'(POT_DEADZONE));
	endfunction

	assign playing = (state != sIdle);

	// Ball edge centres against the paddles
	assign leftHit = inBox(ballX, ballCenterY, X_BITS'(LEFT_PADDLE_X), leftPaddleY,
		PADDLE_W, PADDLE_H);
	assign rightHit = inBox(ballRightX, ballCenterY, X_BITS'(RIGHT_PADDLE_X), rightPaddleY,
		PADDLE_W, PADDLE_H);
	assign speedUp = (leftHit || rightHit) && (hitCount == HIT_BITS'(HITS_PER_SPEEDUP - 1));

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state <= sIdle;
			ballX <= X_BITS'(BALL_START_X);
			ballY <= Y_BITS'(BALL_START_Y);
			ballDirX <= 1'b1;
			ballDirY <= 1'b0;
			speedX <= SPEED_BITS'(START_SPEED);
			speedY <= SPEED_BITS'(START_SPEED);
			hitCount <= '0;
			waitCount <= '0;
			ballRightX <= '0;
			ballCenterY <= '0;
			leftPaddleY <= '0;
			rightPaddleY <= '0;
			objColor <= '0;
			p1Score <= '0;
			p2Score <= '0;
		end
		else if (gameStep)
		begin
			case (state)
				sIdle:
					if (startButton)
					begin
						p1Score <= '0;
						p2Score <= '0;
						ballX <= X_BITS'(BALL_START_X);
						ballY <= Y_BITS'(BALL_START_Y);
						ballDirX <= 1'b1;		// Right and up
						ballDirY <= 1'b0;
						speedX <= SPEED_BITS'(START_SPEED);
						speedY <= SPEED_BITS'(START_SPEED);
						hitCount <= '0;
						waitCount <= '0;
						state <= sServeWait;
					end
				sServeWait:
					if (waitCount == WAIT_BITS'(SERVE_WAIT_STEPS - 1))
					begin
						waitCount <= '0;
						state <= sPaddles;
					end
					else
						waitCount <= waitCount + 1'b1;
				sPaddles:
				begin
					leftPaddleY <= potToPaddle(pot1);
					rightPaddleY <= potToPaddle(pot2);
					objColor.raw <= colorSwitches;
					if (waitCount == WAIT_BITS'(PADDLE_REPEATS - 1))
					begin
						waitCount <= '0;
						state <= sBallMove;
					end
					else
						waitCount <= waitCount + 1'b1;
				end
				sBallMove:
				begin
					ballX <= ballDirX ? ballX + X_BITS'(speedX) : ballX - X_BITS'(speedX);
					ballY <= ballDirY ? ballY + Y_BITS'(speedY) : ballY - Y_BITS'(speedY);
					state <= sBallEdge;
				end
				sBallEdge:
				begin
					ballRightX <= ballX + X_BITS'(BALL_SIZE);
					ballCenterY <= ballY + Y_BITS'(BALL_SIZE / 2);
					state <= sCollide;
				end
				sCollide:
				begin
					if (ballY < Y_BITS'(speedY))
						ballDirY <= 1'b1;		// Top wall
					else if (ballY >= Y_BITS'(WALL_BOTTOM_Y))
						ballDirY <= 1'b0;
					if (leftHit)
						ballDirX <= 1'b1;
					if (rightHit)
						ballDirX <= 1'b0;
					if (leftHit || rightHit)
						hitCount <= speedUp ? '0 : hitCount + 1'b1;
					if (speedUp)
					begin
						speedX <= speedX + 1'b1;
						speedY <= speedY + 1'b1;
					end
					if (ballX < X_BITS'(speedX))
						state <= sP2Score;	// Past the left goal
					else if (ballX >= X_BITS'(GOAL_RIGHT_X))
						state <= sP1Score;
					else
						state <= sPaddles;
				end
				sP1Score:
				begin
					p1Score <= p1Score + 1'b1;
					ballX <= X_BITS'(BALL_START_X);
					ballY <= Y_BITS'(BALL_START_Y);
					ballDirX <= 1'b0;			// Toward player 1
					ballDirY <= 1'b0;
					speedX <= SPEED_BITS'(SERVE_SPEED);
					speedY <= SPEED_BITS'(SERVE_SPEED);
					hitCount <= '0;
					waitCount <= '0;
					state <= (p1Score == SCORE_BITS'(WIN_SCORE - 1)) ? sP1Win : sServeWait;
				end
				sP2Score:
				begin
					p2Score <= p2Score + 1'b1;
					ballX <= X_BITS'(BALL_START_X);
					ballY <= Y_BITS'(BALL_START_Y);
					ballDirX <= 1'b1;			// Toward player 2
					ballDirY <= 1'b0;
					speedX <= SPEED_BITS'(SERVE_SPEED);
					speedY <= SPEED_BITS'(SERVE_SPEED);
					hitCount <= '0;
					waitCount <= '0;
					state <= (p2Score == SCORE_BITS'(WIN_SCORE - 1)) ? sP2Win : sServeWait;
				end
				sP1Win, sP2Win:
				begin
					waitCount <= '0;
					state <= sEndWait;
				end
				sEndWait:
					if (waitCount == WAIT_BITS'(END_WAIT_STEPS - 1))
					begin
						waitCount <= '0;
						state <= sIdle;			// Scores stay up
					end
					else
						waitCount <= waitCount + 1'b1;
				default:
					state <= sIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== vgaTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

module vgaTiming import displayPkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	output logic hSync,					// Active low
	output logic vSync,					// Active low
	output logic inDisplayArea,
	output logic [X_BITS-1:0] pixelX,
	output logic [Y_BITS-1:0] pixelY
);

	logic lineEnd;

	assign lineEnd = (pixelX == X_BITS'(H_TOTAL - 1));
	assign inDisplayArea = (pixelX < X_BITS'(H_VISIBLE)) && (pixelY < Y_BITS'(V_VISIBLE));

	// Pixel and line counters
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			pixelX <= '0;
			pixelY <= '0;
		end
		else if (lineEnd)
		begin
			pixelX <= '0;
			if (pixelY == Y_BITS'(V_TOTAL - 1))
				pixelY <= '0;				// New frame
			else
				pixelY <= pixelY + 1'b1;
		end
		else
			pixelX <= pixelX + 1'b1;
	end

	// Sync one clock behind the counters, in step with RGB
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			hSync <= 1'b1;
			vSync <= 1'b1;
		end
		else
		begin
			hSync <= !((pixelX >= X_BITS'(H_VISIBLE + H_FRONT))
				&& (pixelX < X_BITS'(H_VISIBLE + H_FRONT + H_SYNC)));
			vSync <= !((pixelY >= Y_BITS'(V_VISIBLE + V_FRONT))
				&& (pixelY < Y_BITS'(V_VISIBLE + V_FRONT + V_SYNC)));
		end
	end

endmodule

`default_nettype wire

// ==== gamePkg.sv ====
`default_nettype none

package gamePkg;

	////////////////////
	// Game FSM states
	typedef enum logic [3:0] {
		sIdle,
		sServeWait,
		sPaddles,
		sBallMove,
		sBallEdge,				// Edge points of the moved ball
		sCollide,
		sP1Score,
		sP2Score,
		sP1Win,
		sP2Win,
		sEndWait
	} gameState_e;

	// Ball
	localparam int BALL_SIZE = 10;
	localparam int BALL_START_X = 315;	// Centre of the field
	localparam int BALL_START_Y = 235;

	// Paddles
	localparam int PADDLE_W = 10;
	localparam int PADDLE_H = 50;
	localparam int LEFT_PADDLE_X = 40;
	localparam int RIGHT_PADDLE_X = 600;
	localparam int POT_DEADZONE = 41;
	localparam int PADDLE_MAX_Y = 430;	// Paddle bottom on the last line

	// Field edges
	localparam int GOAL_RIGHT_X = 630;
	localparam int WALL_BOTTOM_Y = 470;

	// Speeds and rounds
	localparam int START_SPEED = 2;
	localparam int SERVE_SPEED = 1;
	localparam int SPEED_BITS = 7;
	localparam int PADDLE_REPEATS = 4;
	localparam int HITS_PER_SPEEDUP = 4;
	localparam int HIT_BITS = $clog2(HITS_PER_SPEEDUP);

	// Scores and waits
	localparam int WIN_SCORE = 5;
	localparam int SCORE_BITS = 4;
	localparam int SERVE_WAIT_STEPS = 4;
	localparam int END_WAIT_STEPS = 8;
	localparam int WAIT_BITS = $clog2(END_WAIT_STEPS);	// Longest wait
	localparam int SCAN_SHIFT = 4;

	////////////////////
	// Seven segments, active low, a in bit 6 down to g in bit 0
	typedef logic [6:0] segments_t;

	function automatic segments_t hexToSegments(input logic [3:0] value);
		case (value)
			4'h0: return 7'b0000001;
			4'h1: return 7'b1001111;
			4'h2: return 7'b0010010;
			4'h3: return 7'b0000110;
			4'h4: return 7'b1001100;
			4'h5: return 7'b0100100;
			4'h6: return 7'b0100000;
			4'h7: return 7'b0001111;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0000100;
			4'hA: return 7'b0001000;
			4'hB: return 7'b1100000;	// Lower case b
			4'hC: return 7'b0110001;
			4'hD: return 7'b1000010;	// Lower case d
			4'hE: return 7'b0110000;
			default: return 7'b0111000;	// F
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== displayPkg.sv ====
`default_nettype none

package displayPkg;

	////////////////////
	// Line timing in pixel clocks
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_TOTAL = 800;

	// Frame timing in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 525;

	localparam int X_BITS = 11;			// Covers H_TOTAL
	localparam int Y_BITS = 10;			// Covers V_TOTAL

	////////////////////
	// Colour byte as RRRGGGBB
	typedef union packed {
		logic [7:0] raw;				// Straight from the switches
		struct packed {
			logic [2:0] red;
			logic [2:0] green;
			logic [1:0] blue;
		} rgb;
	} colorWord_u;

	// Dotted centre line
	localparam int BORDER_X = 319;
	localparam int BORDER_W = 2;
	localparam int BORDER_DASH = 10;	// Rows per dash and per gap

	// On-screen score digits
	localparam int DIGIT_SCALE_SHIFT = 2;	// 4x4 pixel cells
	localparam int LEFT_DIGIT_X = 255;
	localparam int RIGHT_DIGIT_X = 345;
	localparam int DIGIT_Y = 10;

	// Point inside a w by h box whose top left is (boxX, boxY)
	function automatic logic inBox(
		input logic [X_BITS-1:0] px,
		input logic [Y_BITS-1:0] py,
		input logic [X_BITS-1:0] boxX,
		input logic [Y_BITS-1:0] boxY,
		input int unsigned w,
		input int unsigned h
	);
		return (px >= boxX) && (px < boxX + X_BITS'(w))
			&& (py >= boxY) && (py < boxY + Y_BITS'(h));
	endfunction

endpackage

`default_nettype wire
